/* logic/cpu.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    output logic                  fetch_req,
    output logic [`WORD_SIZE-1:0] fetch_addr,
    input  logic                  fetch_ready,
    input  logic [`WORD_SIZE-1:0] fetch_data,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic                  output_valid,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic                  is_halted
);

    fetch_t  if_id;
    decode_t id_ex;
    retire_t ex_wb;

    logic [`REG_ADDR_SIZE-1:0] rd_addr_a;
    logic [`REG_ADDR_SIZE-1:0] rd_addr_b;
    logic [`WORD_SIZE-1:0]     rd_data_a;
    logic [`WORD_SIZE-1:0]     rd_data_b;

    logic                      wr_en;
    logic [`REG_ADDR_SIZE-1:0] wr_addr;
    logic [`WORD_SIZE-1:0]     wr_data;

    ////////////////////////////////////////
    // IF

    fetch_unit i_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .if_id       (if_id)
    );

    ////////////////////////////////////////
    // ID

    decode_stage i_decode (
        .clk       (clk),
        .reset_n   (reset_n),
        .if_id     (if_id),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .id_ex     (id_ex)
    );

    register_file i_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    ////////////////////////////////////////
    // EX and retire

    execute_stage i_execute (
        .clk     (clk),
        .reset_n (reset_n),
        .id_ex   (id_ex),
        .ex_wb   (ex_wb)
    );

    retire_unit i_retire (
        .clk          (clk),
        .reset_n      (reset_n),
        .ex_wb        (ex_wb),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

endmodule

/* logic/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define WORD_SIZE     16
`define REG_ADDR_SIZE 2
`define NUM_REGS      4
`define IMM_SIZE      8

// instruction field widths
`define OPCODE_SIZE   4
`define FUNCT_SIZE    6
`define ALU_OP_SIZE   4

// msb of each instruction field
`define OPCODE_MSB    15
`define RS_MSB        11
`define RT_MSB        9
`define RD_MSB        7
`define FUNCT_MSB     5

`endif

/* logic/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

    typedef enum logic [`OPCODE_SIZE-1:0] {
        ADI    = 4'd4,
        ORI    = 4'd5,
        LHI    = 4'd6,
        R_TYPE = 4'd15
    } opcode_t;

    typedef enum logic [`FUNCT_SIZE-1:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        WWD = 6'd28,
        HLT = 6'd29
    } funct_t;

    typedef enum logic [`ALU_OP_SIZE-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,    // twos complement
        ALU_SHL,
        ALU_SHR,
        ALU_PASS_B
    } alu_op_t;

    ////////////////////////////////////////
    // pipeline registers

    typedef struct packed {
        logic                   valid;
        logic [`WORD_SIZE-1:0]  inst;
        logic [`WORD_SIZE-1:0]  pc;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        alu_op_t                   alu_op;
        logic [`WORD_SIZE-1:0]     op_a;     // rs value
        logic [`WORD_SIZE-1:0]     op_b;     // rt value
        logic [`REG_ADDR_SIZE-1:0] rs;
        logic [`REG_ADDR_SIZE-1:0] rt;
        logic                      use_imm;
        logic [`WORD_SIZE-1:0]     imm;      // already extended
        logic [`REG_ADDR_SIZE-1:0] dest;
        logic                      reg_write;
        logic                      wwd;
        logic                      halt;
    } decode_t;

    typedef struct packed {
        logic                      valid;
        logic [`WORD_SIZE-1:0]     result;
        logic [`REG_ADDR_SIZE-1:0] dest;
        logic                      reg_write;
        logic                      wwd;
        logic [`WORD_SIZE-1:0]     wwd_value;
        logic                      halt;
    } retire_t;

endpackage

/* logic/decode_stage.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_n,
    input  fetch_t                    if_id,
    output logic [`REG_ADDR_SIZE-1:0] rd_addr_a,
    output logic [`REG_ADDR_SIZE-1:0] rd_addr_b,
    input  logic [`WORD_SIZE-1:0]     rd_data_a,
    input  logic [`WORD_SIZE-1:0]     rd_data_b,
    output decode_t                   id_ex
);

    opcode_t                   opcode;
    funct_t                    funct;
    logic [`REG_ADDR_SIZE-1:0] rs;
    logic [`REG_ADDR_SIZE-1:0] rt;
    logic [`REG_ADDR_SIZE-1:0] rd;
    logic [`IMM_SIZE-1:0]      imm8;
    decode_t                   dec;

    assign opcode = opcode_t'(if_id.inst[`OPCODE_MSB -: `OPCODE_SIZE]);
    assign funct  = funct_t'(if_id.inst[`FUNCT_MSB -: `FUNCT_SIZE]);
    assign rs     = if_id.inst[`RS_MSB -: `REG_ADDR_SIZE];
    assign rt     = if_id.inst[`RT_MSB -: `REG_ADDR_SIZE];
    assign rd     = if_id.inst[`RD_MSB -: `REG_ADDR_SIZE];
    assign imm8   = if_id.inst[`IMM_SIZE-1:0];

    assign rd_addr_a = rs;
    assign rd_addr_b = rt;

    ////////////////////////////////////////
    // control decode

    always_comb begin
        dec         = '0;    // unknown encodings retire as no-ops
        dec.valid   = if_id.valid;
        dec.alu_op  = ALU_ADD;
        dec.op_a    = rd_data_a;
        dec.op_b    = rd_data_b;
        dec.rs      = rs;
        dec.rt      = rt;

        case (opcode)
            R_TYPE: begin
                dec.dest      = rd;
                dec.reg_write = 1'b1;
                case (funct)
                    ADD: dec.alu_op = ALU_ADD;
                    SUB: dec.alu_op = ALU_SUB;
                    AND: dec.alu_op = ALU_AND;
                    ORR: dec.alu_op = ALU_OR;
                    NOT: dec.alu_op = ALU_NOT;
                    TCP: dec.alu_op = ALU_TCP;
                    SHL: dec.alu_op = ALU_SHL;
                    SHR: dec.alu_op = ALU_SHR;
                    WWD: begin
                        dec.reg_write = 1'b0;
                        dec.wwd       = 1'b1;    // value taken from rs
                    end
                    HLT: begin
                        dec.reg_write = 1'b0;
                        dec.halt      = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            ADI: begin
                dec.alu_op    = ALU_ADD;
                dec.use_imm   = 1'b1;
                dec.imm       = {{(`WORD_SIZE-`IMM_SIZE){imm8[`IMM_SIZE-1]}}, imm8};
                dec.dest      = rt;
                dec.reg_write = 1'b1;
            end
            ORI: begin
                dec.alu_op    = ALU_OR;
                dec.use_imm   = 1'b1;
                dec.imm       = {{(`WORD_SIZE-`IMM_SIZE){1'b0}}, imm8};
                dec.dest      = rt;
                dec.reg_write = 1'b1;
            end
            LHI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.imm       = {imm8, {(`WORD_SIZE-`IMM_SIZE){1'b0}}};
                dec.dest      = rt;
                dec.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // ID/EX
    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (reset_n) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module execute_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  decode_t id_ex,
    output retire_t ex_wb
);

    logic                  fwd_a;
    logic                  fwd_b;
    logic [`WORD_SIZE-1:0] src_a;
    logic [`WORD_SIZE-1:0] src_b_reg;
    logic [`WORD_SIZE-1:0] src_b;
    logic [`WORD_SIZE-1:0] alu_out;
    retire_t               nxt;

    ////////////////////////////////////////
    // forwarding from EX/WB

    assign fwd_a = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest == id_ex.rs);
    assign fwd_b = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest == id_ex.rt);

    assign src_a     = fwd_a ? ex_wb.result : id_ex.op_a;
    assign src_b_reg = fwd_b ? ex_wb.result : id_ex.op_b;
    assign src_b     = id_ex.use_imm ? id_ex.imm : src_b_reg;

    ////////////////////////////////////////
    // ALU

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_out = src_a + src_b;
            ALU_SUB:    alu_out = src_a - src_b;
            ALU_AND:    alu_out = src_a & src_b;
            ALU_OR:     alu_out = src_a | src_b;
            ALU_NOT:    alu_out = ~src_a;
            ALU_TCP:    alu_out = ~src_a + `WORD_SIZE'd1;
            ALU_SHL:    alu_out = {src_a[`WORD_SIZE-2:0], 1'b0};
            ALU_SHR:    alu_out = {src_a[`WORD_SIZE-1], src_a[`WORD_SIZE-1:1]};  // arithmetic
            ALU_PASS_B: alu_out = src_b;    // LHI
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        nxt.valid     = id_ex.valid;
        nxt.result    = alu_out;
        nxt.dest      = id_ex.dest;
        nxt.reg_write = id_ex.reg_write;
        nxt.wwd       = id_ex.wwd;
        nxt.wwd_value = src_a;
        nxt.halt      = id_ex.halt;
    end

    // EX/WB
    always_ff @(posedge clk) begin
        ex_wb <= nxt;
        if (reset_n) begin
            ex_wb.valid <= 1'b0;
        end
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module fetch_unit import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    output logic                  fetch_req,
    output logic [`WORD_SIZE-1:0] fetch_addr,
    input  logic                  fetch_ready,
    input  logic [`WORD_SIZE-1:0] fetch_data,
    output fetch_t                if_id
);

    logic [`WORD_SIZE-1:0] pc;
    logic                  hlt_seen;
    logic                  take;
    logic                  take_hlt;

    assign fetch_addr = pc;    // held until the transfer
    assign take       = fetch_req & fetch_ready;

    // stop requesting once HLT is accepted
    assign take_hlt = take
        && (fetch_data[`OPCODE_MSB -: `OPCODE_SIZE] == R_TYPE)
        && (fetch_data[`FUNCT_MSB -: `FUNCT_SIZE] == HLT);

    always_ff @(posedge clk) begin
        if_id.inst <= fetch_data;
        if_id.pc   <= pc;

        if (reset_n) begin
            pc          <= '0;
            hlt_seen    <= 1'b0;
            fetch_req   <= 1'b0;
            if_id.valid <= 1'b0;
        end else begin
            if (take) begin
                pc <= pc + `WORD_SIZE'd1;
            end
            if (take_hlt) begin
                hlt_seen <= 1'b1;
            end
            fetch_req   <= ~(hlt_seen | take_hlt);
            if_id.valid <= take;    // bubble when memory is not ready
        end
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module register_file (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [`REG_ADDR_SIZE-1:0] rd_addr_a,
    input  logic [`REG_ADDR_SIZE-1:0] rd_addr_b,
    output logic [`WORD_SIZE-1:0]     rd_data_a,
    output logic [`WORD_SIZE-1:0]     rd_data_b,
    input  logic                      wr_en,
    input  logic [`REG_ADDR_SIZE-1:0] wr_addr,
    input  logic [`WORD_SIZE-1:0]     wr_data
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // decode sees the value retiring this cycle
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

/* logic/retire_unit.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module retire_unit import cpu_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_n,
    input  retire_t                   ex_wb,
    output logic                      wr_en,
    output logic [`REG_ADDR_SIZE-1:0] wr_addr,
    output logic [`WORD_SIZE-1:0]     wr_data,
    output logic [`WORD_SIZE-1:0]     output_port,
    output logic                      output_valid,
    output logic [`WORD_SIZE-1:0]     num_inst,
    output logic                      is_halted
);

    logic [`WORD_SIZE-1:0] count_q;
    logic [`WORD_SIZE-1:0] port_q;
    logic                  halt_q;
    logic                  wwd_retire;
    logic                  halt_retire;

    assign wr_en   = ex_wb.valid & ex_wb.reg_write;
    assign wr_addr = ex_wb.dest;
    assign wr_data = ex_wb.result;

    assign wwd_retire  = ex_wb.valid & ex_wb.wwd;
    assign halt_retire = ex_wb.valid & ex_wb.halt;

    // effects show while the instruction sits in EX/WB
    assign num_inst     = count_q + `WORD_SIZE'(ex_wb.valid);
    assign output_valid = wwd_retire;
    assign output_port  = wwd_retire ? ex_wb.wwd_value : port_q;
    assign is_halted    = halt_q | halt_retire;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            count_q <= '0;
            port_q  <= '0;
            halt_q  <= 1'b0;
        end else begin
            if (ex_wb.valid) begin
                count_q <= count_q + `WORD_SIZE'd1;
            end
            if (wwd_retire) begin
                port_q <= ex_wb.wwd_value;    // hold last value
            end
            if (halt_retire) begin
                halt_q <= 1'b1;
            end
        end
    end

endmodule

/* project.f */
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/retire_unit.sv
logic/cpu.sv
verification/inst_memory.sv
verification/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cpu_tb -f project.f -o cpu_sim

./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

/* verification/cpu_tb.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int          PROG_LEN  = 120;
    localparam int          MEM_WORDS = 256;
    localparam int          ADDR_W    = $clog2(MEM_WORDS);
    localparam int          TIMEOUT   = 4000;
    localparam logic [31:0] SEED      = 32'h7e27;
    localparam logic [ADDR_W-1:0] HLT_ADDR = ADDR_W'(PROG_LEN);

    logic                  clk;
    logic                  reset_n;
    logic                  fetch_req;
    logic [`WORD_SIZE-1:0] fetch_addr;
    logic                  fetch_ready;
    logic [`WORD_SIZE-1:0] fetch_data;
    logic [`WORD_SIZE-1:0] output_port;
    logic                  output_valid;
    logic [`WORD_SIZE-1:0] num_inst;
    logic                  is_halted;

    logic [`WORD_SIZE-1:0] image [MEM_WORDS];
    logic [`WORD_SIZE-1:0] exp_out [MEM_WORDS];    // model value of each WWD
    logic                  is_wwd [MEM_WORDS];
    integer                seed;
    int                    wwd_total;
    int                    wwd_seen;
    int                    retired;
    int                    next_pc;
    logic                  halted_exp;
    logic                  pipe_v [3];
    logic [ADDR_W-1:0]     pipe_a [3];

    cpu i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_ready  (fetch_ready),
        .fetch_data   (fetch_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    inst_memory #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) i_mem (
        .clk         (clk),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .image       (image)
    );

    task automatic stop_with_fail();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch_error(string name, logic [`WORD_SIZE-1:0] got,
                                  logic [`WORD_SIZE-1:0] exp);
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        stop_with_fail();
    endtask

    task automatic plain_error(string what);
        $display("ERROR: %s", what);
        stop_with_fail();
    endtask

    ////////////////////////////////////////
    // program and reference model

    function automatic logic [`WORD_SIZE-1:0] model_alu(funct_t fn, logic [`WORD_SIZE-1:0] a,
                                                        logic [`WORD_SIZE-1:0] b);
        case (fn)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            ORR:     return a | b;
            NOT:     return ~a;
            TCP:     return `WORD_SIZE'd0 - a;
            SHL:     return a << 1;
            SHR:     return $unsigned($signed(a) >>> 1);    // sign kept
            default: return '0;
        endcase
    endfunction

    // half the picks reuse the last destination
    function automatic logic [1:0] pick_reg(logic [1:0] last);
        integer r;
        r = $random(seed);
        if (r[0]) begin
            return last;
        end
        return r[2:1];
    endfunction

    task automatic build_program();
        logic [`WORD_SIZE-1:0] regs [`NUM_REGS];
        logic [`WORD_SIZE-1:0] a;
        logic [1:0]            rs;
        logic [1:0]            rt;
        logic [1:0]            rd;
        logic [1:0]            last;
        logic [7:0]            imm;
        logic [ADDR_W-1:0]     pc;
        int                    kind;
        for (int i = 0; i < MEM_WORDS; i++) begin
            image[i[ADDR_W-1:0]]   = `WORD_SIZE'(i);    // opcode 0 never reaches decode
            exp_out[i[ADDR_W-1:0]] = '0;
            is_wwd[i[ADDR_W-1:0]]  = 1'b0;
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] = '0;
        end
        last      = 2'd0;
        wwd_total = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            pc   = i[ADDR_W-1:0];
            rs   = pick_reg(last);
            rt   = pick_reg(last);
            rd   = 2'($random(seed));
            imm  = 8'($random(seed));
            kind = $unsigned($random(seed)) % 16;
            a    = regs[rs];
            if (kind < 8) begin    // ADD..SHR are funct 0..7
                image[pc] = {R_TYPE, rs, rt, rd, 6'(kind)};
                regs[rd]  = model_alu(funct_t'(6'(kind)), a, regs[rt]);
                last      = rd;
            end else if (kind == 8) begin
                image[pc] = {ADI, rs, rt, imm};
                regs[rt]  = a + {{8{imm[7]}}, imm};
                last      = rt;
            end else if (kind == 9) begin
                image[pc] = {ORI, rs, rt, imm};
                regs[rt]  = a | {8'h00, imm};
                last      = rt;
            end else if (kind == 10) begin
                image[pc] = {LHI, rs, rt, imm};
                regs[rt]  = {imm, 8'h00};
                last      = rt;
            end else begin
                image[pc]   = {R_TYPE, rs, 4'b0000, WWD};
                exp_out[pc] = a;
                is_wwd[pc]  = 1'b1;
                wwd_total++;
            end
        end
        image[HLT_ADDR] = {R_TYPE, 6'b000000, HLT};
    endtask

    ////////////////////////////////////////
    // clock, reset and run

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!is_halted) begin
            @(negedge clk);
            cycles++;
            assert (cycles < TIMEOUT) else plain_error("timeout waiting for is_halted");
        end
    endtask

    initial begin
        seed    = SEED;
        reset_n = 1'b1;
        build_program();
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b0;
        wait_for_halt();
        #1;
        assert (num_inst == `WORD_SIZE'(PROG_LEN + 1))
            else mismatch_error("num_inst", num_inst, `WORD_SIZE'(PROG_LEN + 1));
        assert (wwd_seen == wwd_total)
            else plain_error("halted before every WWD value appeared");
        repeat (20) begin
            @(negedge clk);
            assert (!fetch_req) else plain_error("fetch_req raised again after HLT");
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    ////////////////////////////////////////
    // retirement 3 cycles after each transfer

    initial begin : monitor
        logic                  ret_v;
        logic [ADDR_W-1:0]     ret_a;
        logic                  wwd_now;
        logic [`WORD_SIZE-1:0] exp_port;
        retired    = 0;
        wwd_seen   = 0;
        next_pc    = 0;
        halted_exp = 1'b0;
        exp_port   = '0;
        for (int i = 0; i < 3; i++) begin
            pipe_v[i] = 1'b0;
            pipe_a[i] = '0;
        end
        @(posedge clk);
        forever begin
            @(negedge clk);
            ret_v     = pipe_v[2];
            ret_a     = pipe_a[2];
            pipe_v[2] = pipe_v[1];
            pipe_a[2] = pipe_a[1];
            pipe_v[1] = pipe_v[0];
            pipe_a[1] = pipe_a[0];
            pipe_v[0] = fetch_req && fetch_ready;    // transfer on the coming edge
            pipe_a[0] = fetch_addr[ADDR_W-1:0];
            if (pipe_v[0]) begin
                assert (fetch_addr == `WORD_SIZE'(next_pc))
                    else mismatch_error("fetch_addr", fetch_addr, `WORD_SIZE'(next_pc));
                next_pc++;
            end
            if (ret_v) begin
                retired++;
            end
            assert (num_inst == `WORD_SIZE'(retired))
                else mismatch_error("num_inst", num_inst, `WORD_SIZE'(retired));
            wwd_now = ret_v && is_wwd[ret_a];
            assert (output_valid == wwd_now)
                else mismatch_error("output_valid", `WORD_SIZE'(output_valid),
                                    `WORD_SIZE'(wwd_now));
            if (wwd_now) begin
                exp_port = exp_out[ret_a];
                wwd_seen++;
            end
            // port keeps the last WWD value between pulses
            assert (output_port == exp_port)
                else mismatch_error("output_port", output_port, exp_port);
            if (ret_v && ret_a == HLT_ADDR) begin
                halted_exp = 1'b1;
            end
            assert (is_halted == halted_exp)
                else mismatch_error("is_halted", `WORD_SIZE'(is_halted),
                                    `WORD_SIZE'(halted_exp));
        end
    end

endmodule

/* verification/inst_memory.sv */
`timescale 1ns/1ns
`include "cpu_macros.svh"

module inst_memory #(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] SEED      = 32'h7e27
) (
    input  logic                  clk,
    input  logic                  fetch_req,
    input  logic [`WORD_SIZE-1:0] fetch_addr,
    output logic                  fetch_ready,
    output logic [`WORD_SIZE-1:0] fetch_data,
    input  logic [`WORD_SIZE-1:0] image [MEM_WORDS]
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    integer seed;
    int     delay;
    logic   will_take;

    ////////////////////////////////////////
    // ready after 0 to 3 waiting cycles

    initial begin
        seed        = SEED;
        fetch_ready = 1'b0;
        fetch_data  = '0;
        will_take   = 1'b0;
        delay       = $unsigned($random(seed)) % 4;
        forever begin
            @(posedge clk);
            #1;
            if (will_take) begin    // word went out on this edge
                fetch_ready = 1'b0;
                delay       = $unsigned($random(seed)) % 4;
            end
            if (fetch_req && !fetch_ready) begin
                if (delay == 0) begin
                    fetch_ready = 1'b1;
                    fetch_data  = image[fetch_addr[ADDR_W-1:0]];
                end else begin
                    delay--;
                end
            end
            // req and ready hold until the next edge
            will_take = fetch_req && fetch_ready;
        end
    end

endmodule
